// ==== dv/tb_rv_core.sv ====
`timescale 1ns/10ps
// Directed testbench for the RV32I multi-cycle core with a random-latency memory model
module tb_rv_core;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic        mem_read;
  logic        mem_write;
  logic        mem_resp;
  logic        halted;

  logic [31:0] mem [256];                    // Word array, byte address bits 9:2
  logic [31:0] prog[$];                      // Program image, placed at address 0
  logic [31:0] rd_log[$];                    // Addresses of completed reads
  logic [31:0] st_addr[$];
  logic [31:0] st_data[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];
  int          slot;                         // Next free store slot

  rv_core dut (
    .clk(clk), .rst_n(rst_n), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata), .mem_read(mem_read), .mem_write(mem_write),
    .mem_resp(mem_resp), .halted(halted)
  );

  always #2 clk = ~clk;  // 4 ns period

  // Memory answers each request after 0 to 5 wait cycles, one-cycle mem_resp pulse
  initial begin : mem_model
    int wait_left;
    void'($urandom(32'he4e0));  // Seeds the latency draws of this process
    wait_left = -1;
    mem_resp  <= 1'b0;
    mem_rdata <= '0;
    forever begin
      @(posedge clk);
      if (!rst_n || mem_resp) begin
        mem_resp <= 1'b0;
        wait_left = -1;
      end else if (mem_read || mem_write) begin
        if (wait_left < 0) wait_left = $urandom_range(5, 0);  // New request
        if (wait_left == 0) begin
          mem_resp <= 1'b1;
          if (mem_read) begin
            mem_rdata <= mem[mem_addr[9:2]];
            rd_log.push_back(mem_addr);
          end else begin
            mem[mem_addr[9:2]] = mem_wdata;
            st_addr.push_back(mem_addr);
            st_data.push_back(mem_wdata);
          end
        end
        wait_left--;
      end
    end
  end

  // Instruction encoders built from the RV32I formats
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // SW
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, rs1,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic check(string name, logic [31:0] exp_val, logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
      $display("RESULT: FAIL");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic emit(logic [31:0] instr);
    prog.push_back(instr);
  endtask

  // SW of rs into the next slot; expected only if the store must execute
  task automatic emit_store(logic [4:0] rs, logic [31:0] val, bit expected);
    logic [11:0] off;
    off = 12'(32'h100 + slot * 4);
    slot++;
    emit(enc_s(off, rs, 5'd0));
    if (expected) begin
      exp_addr.push_back({20'b0, off});
      exp_data.push_back(val);
    end
  endtask

  // Fresh program, empty expectations, memory filled from the address
  task automatic start_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    slot = 0;
    foreach (mem[i]) mem[i] = 32'h5a00_0000 ^ (i << 2);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      if (i > 0) check("reset outputs", 32'd0, {mem_read, mem_write, halted});
      @(posedge clk);
    end
    rd_log.delete();
    st_addr.delete();
    st_data.delete();
    rst_n <= 1'b1;
  endtask

  task automatic wait_halt(string name);
    int cycles;
    cycles = 0;
    while (halted !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 5000) begin
        $display("Timeout: %s did not reach the halted state in 5000 cycles", name);
        $display("RESULT: FAIL");
        $fatal(1, "Halt wait expired in %s", name);
      end
    end
  endtask

  // Load, reset, run to halt, then compare the store log in order
  task automatic run_program(string name);
    foreach (prog[i]) mem[i] = prog[i];
    apply_reset();
    wait_halt(name);
    check({name, " store count"}, exp_addr.size(), st_addr.size());
    foreach (exp_addr[i]) begin
      check($sformatf("%s store %0d addr", name, i), exp_addr[i], st_addr[i]);
      check($sformatf("%s store %0d data", name, i), exp_data[i], st_data[i]);
    end
  endtask

  task automatic test_reset_fetch();
    start_program();
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit(enc_i(12'd2, 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(enc_i(12'd3, 5'd0, 3'b000, 5'd3, 7'b0010011));
    emit(32'h0000_0000);  // Opcode 0 is outside the subset
    run_program("reset_fetch");
    check("fetch count", 32'd4, rd_log.size());
    foreach (rd_log[i]) check($sformatf("fetch %0d", i), rv_pkg::RESET_PC + i * 4, rd_log[i]);
  endtask

  // Operands are x1 = -7 and x2 = 3
  task automatic test_alu();
    start_program();
    emit(enc_i(12'hff9, 5'd0, 3'b000, 5'd1, 7'b0010011));  // -7
    emit(enc_i(12'd3, 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));  // SUB
    emit_store(5'd3, 32'hffff_fff6, 1);            // -10
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd4));  // SRA
    emit_store(5'd4, 32'hffff_ffff, 1);            // Sign fills every bit
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd5));
    emit_store(5'd5, 32'd1, 1);                    // Signed -7 is below 3
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd6));
    emit_store(5'd6, 32'd0, 1);                    // Unsigned 0xfffffff9 is not below 3
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd7));
    emit_store(5'd7, 32'hffff_fffc, 1);            // -4
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd8));
    emit_store(5'd8, 32'hffff_ffc8, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd9));  // SRL
    emit_store(5'd9, 32'h1fff_ffff, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd10));
    emit_store(5'd10, 32'hffff_fffa, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd11));
    emit_store(5'd11, 32'hffff_fffb, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd12));
    emit_store(5'd12, 32'h0000_0001, 1);
    emit(enc_i({7'h20, 5'd1}, 5'd1, 3'b101, 5'd13, 7'b0010011));  // SRAI 1
    emit_store(5'd13, 32'hffff_fffc, 1);
    emit(enc_i(12'hff8, 5'd1, 3'b010, 5'd14, 7'b0010011));  // SLTI -8
    emit_store(5'd14, 32'd0, 1);
    emit(enc_i(12'hfff, 5'd1, 3'b011, 5'd15, 7'b0010011));  // SLTIU sign-extended max
    emit_store(5'd15, 32'd1, 1);
    emit(enc_i(12'h0f0, 5'd1, 3'b100, 5'd16, 7'b0010011));
    emit_store(5'd16, 32'hffff_ff09, 1);
    emit(enc_i(12'h7ff, 5'd1, 3'b000, 5'd17, 7'b0010011));  // Bit 30 set, still an add
    emit_store(5'd17, 32'h0000_07f8, 1);                   // 2047 - 7
    emit(32'h0000_0000);
    run_program("alu");
  endtask

  task automatic test_upper_load();
    logic [31:0] auipc_pc;
    start_program();
    mem[32'h300 >> 2] = 32'h1234_5678;
    emit(enc_i(12'h300, 5'd0, 3'b010, 5'd1, 7'b0000011));  // LW x1, 0x300(x0)
    emit({20'habcde, 5'd2, 7'b0110111});                    // LUI
    auipc_pc = prog.size() * 4;
    emit({20'h00001, 5'd3, 7'b0010111});                    // AUIPC
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
    emit(enc_r(7'h00, 5'd3, 5'd4, 3'b000, 5'd4));
    emit_store(5'd1, 32'h1234_5678, 1);
    emit_store(5'd3, auipc_pc + 32'h1000, 1);
    emit_store(5'd4, 32'h1234_5678 + 32'habcd_e000 + auipc_pc + 32'h1000, 1);
    emit(enc_i(12'h055, 5'd0, 3'b000, 5'd0, 7'b0010011));  // Writes to x0 are lost
    emit({20'hfffff, 5'd0, 7'b0110111});
    emit_store(5'd0, 32'd0, 1);
    emit(32'h0000_0000);
    run_program("upper_load");
  endtask

  // Branch over the marker store that follows it
  task automatic emit_branch(logic [4:0] rs1, logic [4:0] rs2, logic [2:0] f3, bit taken);
    emit(enc_b(13'd8, rs2, rs1, f3));
    emit_store(5'd5, 32'h5a5, !taken);
  endtask

  task automatic test_branches();
    start_program();
    emit(enc_i(12'hfff, 5'd0, 3'b000, 5'd1, 7'b0010011));  // x1 = -1
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd3, 7'b0010011));
    emit(enc_i(12'h5a5, 5'd0, 3'b000, 5'd5, 7'b0010011));  // Marker value
    emit_branch(5'd2, 5'd3, 3'b000, 1);  // BEQ
    emit_branch(5'd1, 5'd2, 3'b000, 0);
    emit_branch(5'd1, 5'd2, 3'b001, 1);  // BNE
    emit_branch(5'd2, 5'd3, 3'b001, 0);
    emit_branch(5'd1, 5'd2, 3'b100, 1);  // BLT -1 < 1
    emit_branch(5'd2, 5'd1, 3'b100, 0);
    emit_branch(5'd2, 5'd1, 3'b101, 1);  // BGE
    emit_branch(5'd1, 5'd2, 3'b101, 0);
    emit_branch(5'd2, 5'd1, 3'b110, 1);  // BLTU 1 < 0xffffffff
    emit_branch(5'd1, 5'd2, 3'b110, 0);
    emit_branch(5'd1, 5'd2, 3'b111, 1);  // BGEU
    emit_branch(5'd2, 5'd1, 3'b111, 0);
    emit(32'h0000_0000);
    run_program("branches");
  endtask

  task automatic test_jal();
    logic [31:0] jal_pc;
    start_program();
    emit(enc_i(12'd9, 5'd0, 3'b000, 5'd6, 7'b0010011));
    jal_pc = prog.size() * 4;
    emit(enc_j(21'd12, 5'd1));                                // Skips the next two
    emit_store(5'd6, 32'd9, 0);
    emit(enc_i(12'h077, 5'd0, 3'b000, 5'd6, 7'b0010011));
    emit(enc_i(12'h03c, 5'd0, 3'b000, 5'd6, 7'b0010011));  // Jump target
    emit_store(5'd1, jal_pc + 32'd4, 1);
    emit_store(5'd6, 32'h03c, 1);
    emit(32'h0000_0000);
    run_program("jal");
  endtask

  task automatic test_halt();
    start_program();
    emit(enc_i(12'h011, 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit_store(5'd1, 32'h011, 1);
    emit_store(5'd1, 32'h011, 1);
    emit(32'hffff_ffff);          // Opcode 7'h7f
    emit_store(5'd1, 32'h011, 0);  // Never reached
    run_program("halt");
    for (int i = 0; i < 100; i++) begin
      @(negedge clk);
      check("halt watch", 32'd1, {mem_read, mem_write, halted});
    end
  endtask

  initial begin
    test_reset_fetch();
    test_alu();
    test_upper_load();
    test_branches();
    test_jal();
    test_halt();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/rv_pkg.sv
hdl/ctrl_if.sv
hdl/rv_control.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_datapath.sv
hdl/rv_core.sv
dv/tb_rv_core.sv

// ==== hdl/ctrl_if.sv ====
`timescale 1ns/10ps
// Control bundle from the FSM to the datapath, register file and ALU
interface ctrl_if;
  import rv_pkg::*;

  logic     load_pc;
  logic     load_ir;
  logic     load_mar;
  logic     load_mdr;
  logic     load_reg;      // Register file write enable
  a_sel_t   a_sel;
  b_sel_t   b_sel;
  bus_sel_t bus_sel;
  logic     mdr_from_alu;  // MDR takes store data instead of read data
  alu_op_t  alu_op;

  modport ctrl (output load_pc, load_ir, load_mar, load_mdr, load_reg,
                       a_sel, b_sel, bus_sel, mdr_from_alu, alu_op);
  modport dp   (input  load_pc, load_ir, load_mar, load_mdr, load_reg,
                       a_sel, b_sel, bus_sel, mdr_from_alu);
  modport alu  (input  alu_op);

endinterface

// ==== hdl/rv_alu.sv ====
`timescale 1ns/10ps
// RV32I ALU producing the operation result and the branch compare flags
module rv_alu (
  ctrl_if.alu           ctl,
  input  rv_pkg::word_t a,
  input  rv_pkg::word_t b,
  output rv_pkg::word_t result,
  output logic          eq,
  output logic          lt,
  output logic          ltu
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];  // Upper bits of b ignored for shifts

  // Flags always come from a and b, whatever the op
  assign eq  = (a == b);
  assign lt  = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  always_comb begin
    case (ctl.alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, ltu};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;  // Sign bit shifted in
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

endmodule

// ==== hdl/rv_control.sv ====
`timescale 1ns/10ps
// RV32I control FSM sequencing fetch, decode and execute of one instruction at a time
module rv_control (
  input  logic            clk,
  input  logic            rst_n,
  ctrl_if.ctrl            ctl,
  input  rv_pkg::opcode_t opcode,
  input  rv_pkg::funct3_t funct3,
  input  logic            arithmetic,
  input  logic            eq,
  input  logic            lt,
  input  logic            ltu,
  input  logic            mem_resp,
  output logic            mem_read,
  output logic            mem_write,
  output logic            halted
);
  import rv_pkg::*;

  typedef enum logic [4:0] {
    IDLE, FETCH_0, FETCH_1, FETCH_2, FETCH_3, DECODE,
    REG_REG, REG_IMM, LUI_0, AUIPC_0, JAL_0, JAL_1, BRANCH_0, BRANCH_T,
    LD_0, LD_1, LD_2, LD_3, ST_0, ST_1, ST_2, PC_INC, HALT
  } state_t;

  state_t  state, next_state;
  alu_op_t fn_op;     // ALU op from funct3 for R and I type
  logic    br_taken;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // SUB only exists in R type, ADDI ignores bit 30
  always_comb begin
    case (funct3)
      3'b000:  fn_op = (arithmetic && state == REG_REG) ? ALU_SUB : ALU_ADD;
      3'b001:  fn_op = ALU_SLL;
      3'b010:  fn_op = ALU_SLT;
      3'b011:  fn_op = ALU_SLTU;
      3'b100:  fn_op = ALU_XOR;
      3'b101:  fn_op = arithmetic ? ALU_SRA : ALU_SRL;
      3'b110:  fn_op = ALU_OR;
      default: fn_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (funct3)
      F3_BEQ:  br_taken = eq;
      F3_BNE:  br_taken = !eq;
      F3_BLT:  br_taken = lt;
      F3_BGE:  br_taken = !lt;
      F3_BLTU: br_taken = ltu;
      F3_BGEU: br_taken = !ltu;
      default: br_taken = 1'b0;  // Reserved encodings fall through
    endcase
  end

  always_comb begin
    next_state       = state;
    ctl.load_pc      = 1'b0;
    ctl.load_ir      = 1'b0;
    ctl.load_mar     = 1'b0;
    ctl.load_mdr     = 1'b0;
    ctl.load_reg     = 1'b0;
    ctl.a_sel        = A_RS1;
    ctl.b_sel        = B_RS2;
    ctl.bus_sel      = BUS_ALU;
    ctl.mdr_from_alu = 1'b0;
    ctl.alu_op       = ALU_ADD;
    mem_read         = 1'b0;
    mem_write        = 1'b0;
    case (state)
      IDLE: next_state = FETCH_0;
      FETCH_0: begin  // MAR <- PC
        ctl.load_mar = 1'b1;
        ctl.b_sel    = B_PC;
        ctl.alu_op   = ALU_PASS_B;
        next_state   = FETCH_1;
      end
      FETCH_1: begin
        mem_read = 1'b1;  // Held until memory answers
        if (mem_resp) next_state = FETCH_2;
      end
      FETCH_2: begin
        ctl.load_mdr = 1'b1;
        next_state   = FETCH_3;
      end
      FETCH_3: begin
        ctl.load_ir = 1'b1;
        ctl.bus_sel = BUS_MDR;
        next_state  = DECODE;
      end
      DECODE: begin
        case (opcode)
          OP_ALU:    next_state = REG_REG;
          OP_ALUI:   next_state = REG_IMM;
          OP_LUI:    next_state = LUI_0;
          OP_AUIPC:  next_state = AUIPC_0;
          OP_JAL:    next_state = JAL_0;
          OP_BRANCH: next_state = BRANCH_0;
          OP_LOAD:   next_state = LD_0;
          OP_STORE:  next_state = ST_0;
          default:   next_state = HALT;  // Outside the subset
        endcase
      end
      REG_REG, REG_IMM: begin
        ctl.load_reg = 1'b1;
        ctl.b_sel    = (state == REG_IMM) ? B_IMM : B_RS2;
        ctl.alu_op   = fn_op;
        next_state   = PC_INC;
      end
      LUI_0: begin
        ctl.load_reg = 1'b1;
        ctl.b_sel    = B_IMM;
        ctl.alu_op   = ALU_PASS_B;
        next_state   = PC_INC;
      end
      AUIPC_0: begin  // rd <- PC + imm
        ctl.load_reg = 1'b1;
        ctl.a_sel    = A_PC;
        ctl.b_sel    = B_IMM;
        next_state   = PC_INC;
      end
      JAL_0: begin  // Link value PC + 4
        ctl.load_reg = 1'b1;
        ctl.a_sel    = A_FOUR;
        ctl.b_sel    = B_PC;
        next_state   = JAL_1;
      end
      JAL_1, BRANCH_T: begin  // PC <- PC + imm
        ctl.load_pc = 1'b1;
        ctl.a_sel   = A_PC;
        ctl.b_sel   = B_IMM;
        next_state  = FETCH_0;
      end
      BRANCH_0: next_state = br_taken ? BRANCH_T : PC_INC;  // Flags compare rs1 and rs2
      LD_0, ST_0: begin  // Effective address rs1 + imm
        ctl.load_mar = 1'b1;
        ctl.b_sel    = B_IMM;
        next_state   = (state == LD_0) ? LD_1 : ST_1;
      end
      LD_1: begin
        mem_read = 1'b1;
        if (mem_resp) next_state = LD_2;
      end
      LD_2: begin
        ctl.load_mdr = 1'b1;
        next_state   = LD_3;
      end
      LD_3: begin
        ctl.load_reg = 1'b1;
        ctl.bus_sel  = BUS_MDR;
        next_state   = PC_INC;
      end
      ST_1: begin  // MDR <- rs2
        ctl.load_mdr     = 1'b1;
        ctl.mdr_from_alu = 1'b1;
        ctl.alu_op       = ALU_PASS_B;
        next_state       = ST_2;
      end
      ST_2: begin
        mem_write = 1'b1;
        if (mem_resp) next_state = PC_INC;
      end
      PC_INC: begin
        ctl.load_pc = 1'b1;
        ctl.a_sel   = A_FOUR;
        ctl.b_sel   = B_PC;
        next_state  = FETCH_0;
      end
      HALT: next_state = HALT;  // Only reset leaves
      default: next_state = IDLE;
    endcase
  end

  assign halted = (state == HALT);

  // Read and write requests are exclusive
  a_one_req: assert property (@(posedge clk) disable iff (!rst_n) !(mem_read && mem_write));

  // Request stays up until the response cycle
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_read || mem_write) && !mem_resp |=> $stable({mem_read, mem_write}));

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/10ps
// RV32I multi-cycle core top level joining the control FSM and the datapath blocks
module rv_core (
  input  logic          clk,
  input  logic          rst_n,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  input  rv_pkg::word_t mem_rdata,
  output logic          mem_read,
  output logic          mem_write,
  input  logic          mem_resp,
  output logic          halted
);
  import rv_pkg::*;

  word_t    ir;
  word_t    imm;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_result;
  word_t    bus;         // Write data for PC, IR, MAR and registers
  opcode_t  opcode;
  funct3_t  funct3;
  logic     arithmetic;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  logic     eq;
  logic     lt;
  logic     ltu;

  ctrl_if ctl ();

  rv_control u_control (
    .clk(clk), .rst_n(rst_n), .ctl(ctl.ctrl),
    .opcode(opcode), .funct3(funct3), .arithmetic(arithmetic),
    .eq(eq), .lt(lt), .ltu(ltu), .mem_resp(mem_resp),
    .mem_read(mem_read), .mem_write(mem_write), .halted(halted)
  );

  rv_decode u_decode (
    .ir(ir), .opcode(opcode), .funct3(funct3), .arithmetic(arithmetic),
    .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm)
  );

  rv_regfile u_regfile (
    .clk(clk), .ctl(ctl.dp), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wdata(bus), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_alu u_alu (
    .ctl(ctl.alu), .a(alu_a), .b(alu_b),
    .result(alu_result), .eq(eq), .lt(lt), .ltu(ltu)
  );

  rv_datapath u_datapath (
    .clk(clk), .rst_n(rst_n), .ctl(ctl.dp),
    .imm(imm), .rs1_data(rs1_data), .rs2_data(rs2_data), .alu_result(alu_result),
    .mem_rdata(mem_rdata), .mem_resp(mem_resp),
    .ir(ir), .alu_a(alu_a), .alu_b(alu_b), .bus(bus),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

endmodule

// ==== hdl/rv_datapath.sv ====
`timescale 1ns/10ps
// Core datapath with PC, IR, MAR and MDR, the operand muxes and the internal bus
module rv_datapath (
  input  logic          clk,
  input  logic          rst_n,
  ctrl_if.dp            ctl,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t alu_result,
  input  rv_pkg::word_t mem_rdata,
  input  logic          mem_resp,
  output rv_pkg::word_t ir,
  output rv_pkg::word_t alu_a,
  output rv_pkg::word_t alu_b,
  output rv_pkg::word_t bus,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata
);
  import rv_pkg::*;

  word_t pc;
  word_t mar;
  word_t mdr;
  word_t resp_data;  // Read data held past the response cycle

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (ctl.load_pc) begin
      pc <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_resp) resp_data <= mem_rdata;
    if (ctl.load_ir) ir <= bus;
    if (ctl.load_mar) mar <= bus;
    if (ctl.load_mdr) mdr <= ctl.mdr_from_alu ? alu_result : resp_data;  // Store data or read data
  end

  // Operand A
  always_comb begin
    case (ctl.a_sel)
      A_PC:    alu_a = pc;
      A_FOUR:  alu_a = PC_STEP;
      default: alu_a = rs1_data;
    endcase
  end

  // Operand B
  always_comb begin
    case (ctl.b_sel)
      B_IMM:   alu_b = imm;
      B_PC:    alu_b = pc;
      default: alu_b = rs2_data;
    endcase
  end

  assign bus       = (ctl.bus_sel == BUS_MDR) ? mdr : alu_result;
  assign mem_addr  = mar;
  assign mem_wdata = mdr;

  // Every address put into MAR is word aligned
  a_addr_align: assert property (@(posedge clk) disable iff (!rst_n)
    ctl.load_mar |=> mem_addr[1:0] == 2'b00);

endmodule

// ==== hdl/rv_decode.sv ====
`timescale 1ns/10ps
// Instruction field splitter and immediate generator for the RV32I formats
module rv_decode (
  input  rv_pkg::word_t    ir,
  output rv_pkg::opcode_t  opcode,
  output rv_pkg::funct3_t  funct3,
  output logic             arithmetic,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm
);
  import rv_pkg::*;

  assign opcode     = ir[6:0];
  assign rd         = ir[11:7];
  assign funct3     = ir[14:12];
  assign rs1        = ir[19:15];
  assign rs2        = ir[24:20];
  assign arithmetic = ir[30];  // SUB and SRA select

  // Immediate format follows the opcode
  always_comb begin
    case (opcode)
      OP_STORE: begin
        imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      end
      OP_BRANCH: begin  // Halfword offset, bit 0 always clear
        imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      end
      OP_LUI, OP_AUIPC: begin
        imm = {ir[31:12], 12'b0};
      end
      OP_JAL: begin
        imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      end
      default: begin  // I type for loads and ALU immediates
        imm = {{20{ir[31]}}, ir[31:20]};
      end
    endcase
  end

endmodule

// ==== hdl/rv_pkg.sv ====
// RV32I core package with shared widths, instruction encodings and control codes
package rv_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             word_t;     // Data, address or instruction
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
  typedef logic [6:0]                  opcode_t;
  typedef logic [2:0]                  funct3_t;
  typedef logic [3:0]                  alu_op_t;
  typedef logic [1:0]                  a_sel_t;    // ALU operand A source
  typedef logic [1:0]                  b_sel_t;    // ALU operand B source
  typedef logic                        bus_sel_t;  // Internal data bus source

  localparam word_t RESET_PC = 32'h0000_0000;
  localparam word_t PC_STEP  = 32'd4;

  // Major opcodes of the supported subset
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_ALUI   = 7'b0010011;
  localparam opcode_t OP_ALU    = 7'b0110011;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;  // Result is operand B unchanged

  localparam a_sel_t   A_RS1   = 2'd0;
  localparam a_sel_t   A_PC    = 2'd1;
  localparam a_sel_t   A_FOUR  = 2'd2;
  localparam b_sel_t   B_RS2   = 2'd0;
  localparam b_sel_t   B_IMM   = 2'd1;
  localparam b_sel_t   B_PC    = 2'd2;
  localparam bus_sel_t BUS_ALU = 1'b0;
  localparam bus_sel_t BUS_MDR = 1'b1;

endpackage

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/10ps
// Register file with 32 entries, two combinational reads and one clocked write
module rv_regfile (
  input  logic             clk,
  ctrl_if.dp               ctl,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    wdata,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [NUM_REGS];

  // x0 is cleared on every edge and never takes a write
  always_ff @(posedge clk) begin
    regs[0] <= '0;
    if (ctl.load_reg && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // Both ports return zero for x0 even right after a write aimed at it
  a_x0_zero: assert property (@(posedge clk)
    (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0));

endmodule
